//--- logic/route_pkg.sv
`default_nettype none

package route_pkg;

	typedef logic [15:0] word_t;
	typedef logic [15:0] node_id_t;
	// lower q value is better
	typedef logic [15:0] cost_t;
	typedef logic [10:0] mem_addr_t;
	typedef logic [5:0] nbr_idx_t;
	// neighbor count is one bit wider than an index
	typedef logic [$bits(nbr_idx_t):0] nbr_cnt_t;

	localparam mem_addr_t NBR_COUNT_ADDR = 11'h000;
	localparam mem_addr_t NBR_BASE = 11'h010;
	localparam mem_addr_t BETTER_COUNT_ADDR = 11'h1FF;
	localparam mem_addr_t BETTER_BASE = 11'h200;

	// word offsets inside one four-word neighbor entry
	localparam logic [1:0] FLD_ID = 2'd0;
	localparam logic [1:0] FLD_CLUSTER = 2'd1;
	localparam logic [1:0] FLD_BATTERY = 2'd2;
	localparam logic [1:0] FLD_COST = 2'd3;

	localparam node_id_t NO_HOP = 16'hFFFF;

	function automatic mem_addr_t nbr_addr(input nbr_cnt_t idx, input logic [1:0] fld);
		return NBR_BASE + mem_addr_t'({idx, fld});
	endfunction

	// stored count never exceeds the table depth
	function automatic nbr_cnt_t clamp_count(input word_t raw, input int limit);
		if (raw > word_t'(limit)) begin
			return nbr_cnt_t'(limit);
		end
		return nbr_cnt_t'(raw);
	endfunction

endpackage

`default_nettype wire

//--- logic/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	typedef enum logic [2:0] {
		st_idle,
		st_learn,
		st_find,
		st_choose,
		st_done
	} engine_state_t;

	// apb byte offsets
	localparam logic [12:0] REG_CTRL = 13'h000;
	localparam logic [12:0] REG_STATUS = 13'h004;
	localparam logic [12:0] REG_MY_ID = 13'h008;
	localparam logic [12:0] REG_MY_CLUSTER = 13'h00C;
	localparam logic [12:0] REG_MY_COST = 13'h010;
	localparam logic [12:0] REG_EPSILON = 13'h014;
	localparam logic [12:0] REG_PKT_SRC = 13'h018;
	localparam logic [12:0] REG_PKT_CLUSTER = 13'h01C;
	localparam logic [12:0] REG_PKT_BATTERY = 13'h020;
	localparam logic [12:0] REG_PKT_COST = 13'h024;
	localparam logic [12:0] REG_NEXT_HOP = 13'h028;
	// node memory window starts here
	localparam logic [12:0] MEM_WINDOW = 13'h1000;

	localparam int CTRL_START = 0;
	localparam int STAT_BUSY = 0;
	localparam int STAT_DONE = 1;
	localparam int STAT_HOP_VALID = 2;

endpackage

`default_nettype wire

//--- logic/node_memory.sv
`timescale 1ns/1ps
`default_nettype none

module node_memory (
	input wire clock,
	input wire route_pkg::mem_addr_t addr,
	input wire we,
	input wire route_pkg::word_t wdata,
	output route_pkg::word_t rdata
);
	import route_pkg::*;

	word_t mem [0:2**$bits(mem_addr_t)-1];

	// registered read so a same-address write returns the old word
	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

//--- logic/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
	input wire clock,
	input wire nrst,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [12:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire busy,
	input wire done,
	input wire route_pkg::node_id_t next_hop,
	input wire hop_valid,
	output logic start,
	output route_pkg::node_id_t my_id,
	output route_pkg::node_id_t my_cluster,
	output route_pkg::cost_t my_cost,
	output logic [7:0] epsilon,
	output route_pkg::node_id_t pkt_src,
	output route_pkg::node_id_t pkt_cluster,
	output route_pkg::word_t pkt_battery,
	output route_pkg::cost_t pkt_cost,
	output route_pkg::mem_addr_t mem_addr,
	output logic mem_we,
	output route_pkg::word_t mem_wdata,
	input wire route_pkg::word_t mem_rdata
);
	import route_pkg::*;
	import ctrl_pkg::*;

	logic access;
	logic win;
	logic win_rd;
	logic rd_wait;
	word_t reg_rdata;

	assign access = psel & penable;
	assign win = (paddr >= MEM_WINDOW);

	// window reads wait one cycle for the ram
	assign win_rd = access & win & ~pwrite & ~busy;
	assign pready = access & ~(win_rd & ~rd_wait);
	// engine owns the memory while busy
	assign pslverr = access & win & busy;

	// word offset from the window base
	assign mem_addr = mem_addr_t'(paddr[11:2]);
	assign mem_wdata = pwdata[15:0];
	assign mem_we = access & win & pwrite & ~busy;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			rd_wait <= 1'b0;
		end else begin
			rd_wait <= win_rd & ~rd_wait;
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			start <= 1'b0;
			my_id <= '0;
			my_cluster <= '0;
			my_cost <= '0;
			epsilon <= '0;
			pkt_src <= '0;
			pkt_cluster <= '0;
			pkt_battery <= '0;
			pkt_cost <= '0;
		end else begin
			start <= 1'b0;
			if (access & pwrite & ~win) begin
				case (paddr)
					// start is dropped while a run is in flight
					REG_CTRL: start <= pwdata[CTRL_START] & ~busy;
					REG_MY_ID: my_id <= pwdata[15:0];
					REG_MY_CLUSTER: my_cluster <= pwdata[15:0];
					REG_MY_COST: my_cost <= pwdata[15:0];
					REG_EPSILON: epsilon <= pwdata[7:0];
					REG_PKT_SRC: pkt_src <= pwdata[15:0];
					REG_PKT_CLUSTER: pkt_cluster <= pwdata[15:0];
					REG_PKT_BATTERY: pkt_battery <= pwdata[15:0];
					REG_PKT_COST: pkt_cost <= pwdata[15:0];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		reg_rdata = '0;
		case (paddr)
			REG_STATUS: begin
				reg_rdata[STAT_BUSY] = busy;
				reg_rdata[STAT_DONE] = done;
				reg_rdata[STAT_HOP_VALID] = hop_valid;
			end
			REG_MY_ID: reg_rdata = my_id;
			REG_MY_CLUSTER: reg_rdata = my_cluster;
			REG_MY_COST: reg_rdata = my_cost;
			REG_EPSILON: reg_rdata = word_t'(epsilon);
			REG_PKT_SRC: reg_rdata = pkt_src;
			REG_PKT_CLUSTER: reg_rdata = pkt_cluster;
			REG_PKT_BATTERY: reg_rdata = pkt_battery;
			REG_PKT_COST: reg_rdata = pkt_cost;
			REG_NEXT_HOP: reg_rdata = next_hop;
			default: ;
		endcase
	end

	// rejected window reads return zero
	assign prdata = win ? {16'h0, busy ? 16'h0 : mem_rdata} : {16'h0, reg_rdata};

endmodule

`default_nettype wire

//--- logic/learn_costs.sv
`timescale 1ns/1ps
`default_nettype none

module learn_costs #(
	parameter int max_neighbors = 64
) (
	input wire clock,
	input wire nrst,
	input wire go,
	input wire route_pkg::node_id_t pkt_src,
	input wire route_pkg::node_id_t pkt_cluster,
	input wire route_pkg::word_t pkt_battery,
	input wire route_pkg::cost_t pkt_cost,
	output route_pkg::mem_addr_t mem_addr,
	output logic mem_we,
	output route_pkg::word_t mem_wdata,
	input wire route_pkg::word_t mem_rdata,
	output logic finished
);
	import route_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_count,
		s_read_id,
		s_compare,
		s_write,
		s_write_count,
		s_finish
	} learn_state_t;

	learn_state_t state;
	nbr_cnt_t count;
	nbr_cnt_t idx;
	logic [1:0] fld;
	logic append;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= s_idle;
		end else begin
			case (state)
				// count address is already on the bus in idle
				s_idle: if (go) state <= s_count;
				s_count: begin
					count <= clamp_count(mem_rdata, max_neighbors);
					idx <= '0;
					state <= s_read_id;
				end
				s_read_id: begin
					if (idx != count) begin
						state <= s_compare;
					end else if (count < max_neighbors) begin
						append <= 1'b1;
						fld <= FLD_ID;
						state <= s_write;
					end else begin
						// packet dropped when the table is full
						state <= s_finish;
					end
				end
				s_compare: begin
					if (mem_rdata == pkt_src) begin
						append <= 1'b0;
						fld <= FLD_CLUSTER;
						state <= s_write;
					end else begin
						idx <= idx + 1'b1;
						state <= s_read_id;
					end
				end
				s_write: begin
					fld <= fld + 1'b1;
					if (fld == FLD_COST) begin
						state <= append ? s_write_count : s_finish;
					end
				end
				s_write_count: state <= s_finish;
				default: state <= s_idle;
			endcase
		end
	end

	always_comb begin
		mem_addr = nbr_addr(idx, fld);
		mem_we = 1'b0;
		case (fld)
			FLD_ID: mem_wdata = pkt_src;
			FLD_CLUSTER: mem_wdata = pkt_cluster;
			FLD_BATTERY: mem_wdata = pkt_battery;
			default: mem_wdata = pkt_cost;
		endcase
		case (state)
			s_idle: mem_addr = NBR_COUNT_ADDR;
			s_read_id: mem_addr = nbr_addr(idx, FLD_ID);
			s_write: mem_we = 1'b1;
			s_write_count: begin
				mem_addr = NBR_COUNT_ADDR;
				mem_we = 1'b1;
				mem_wdata = word_t'(count + 1'b1);
			end
			default: ;
		endcase
	end

	assign finished = (state == s_finish);

endmodule

`default_nettype wire

//--- logic/find_best.sv
`timescale 1ns/1ps
`default_nettype none

module find_best #(
	parameter int max_neighbors = 64
) (
	input wire clock,
	input wire nrst,
	input wire go,
	input wire route_pkg::node_id_t my_cluster,
	input wire route_pkg::cost_t my_cost,
	output route_pkg::mem_addr_t mem_addr,
	output logic mem_we,
	output route_pkg::word_t mem_wdata,
	input wire route_pkg::word_t mem_rdata,
	output route_pkg::node_id_t best_id,
	output logic best_valid,
	output route_pkg::nbr_cnt_t better_count,
	output logic finished
);
	import route_pkg::*;

	typedef enum logic [3:0] {
		s_idle,
		s_count,
		s_read_cluster,
		s_read_cost,
		s_eval,
		s_write_better,
		s_write_count,
		s_read_best,
		s_get_best,
		s_finish
	} find_state_t;

	find_state_t state;
	nbr_cnt_t count;
	nbr_cnt_t idx;
	nbr_cnt_t best_idx;
	cost_t best_q;
	logic same;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= s_idle;
			best_valid <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (go) begin
						best_valid <= 1'b0;
						better_count <= '0;
						state <= s_count;
					end
				end
				s_count: begin
					count <= clamp_count(mem_rdata, max_neighbors);
					idx <= '0;
					state <= s_read_cluster;
				end
				s_read_cluster: state <= (idx == count) ? s_write_count : s_read_cost;
				s_read_cost: begin
					same <= (mem_rdata == my_cluster);
					state <= s_eval;
				end
				s_eval: begin
					// strict compare keeps the lowest index on a tie
					if (same && (!best_valid || mem_rdata < best_q)) begin
						best_valid <= 1'b1;
						best_q <= mem_rdata;
						best_idx <= idx;
					end
					if (same && mem_rdata < my_cost) begin
						state <= s_write_better;
					end else begin
						idx <= idx + 1'b1;
						state <= s_read_cluster;
					end
				end
				s_write_better: begin
					better_count <= better_count + 1'b1;
					idx <= idx + 1'b1;
					state <= s_read_cluster;
				end
				s_write_count: state <= best_valid ? s_read_best : s_finish;
				s_read_best: state <= s_get_best;
				s_get_best: begin
					best_id <= mem_rdata;
					state <= s_finish;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_comb begin
		mem_addr = nbr_addr(idx, FLD_CLUSTER);
		mem_we = 1'b0;
		mem_wdata = word_t'(idx);
		case (state)
			s_idle: mem_addr = NBR_COUNT_ADDR;
			s_read_cost: mem_addr = nbr_addr(idx, FLD_COST);
			s_write_better: begin
				mem_addr = BETTER_BASE + mem_addr_t'(better_count);
				mem_we = 1'b1;
			end
			s_write_count: begin
				mem_addr = BETTER_COUNT_ADDR;
				mem_we = 1'b1;
				mem_wdata = word_t'(better_count);
			end
			s_read_best: mem_addr = nbr_addr(best_idx, FLD_ID);
			default: ;
		endcase
	end

	assign finished = (state == s_finish);

endmodule

`default_nettype wire

//--- logic/winner_policy.sv
`timescale 1ns/1ps
`default_nettype none

module winner_policy (
	input wire clock,
	input wire nrst,
	input wire go,
	input wire [7:0] epsilon,
	input wire route_pkg::node_id_t best_id,
	input wire best_valid,
	input wire route_pkg::nbr_cnt_t better_count,
	output route_pkg::mem_addr_t mem_addr,
	output logic mem_we,
	output route_pkg::word_t mem_wdata,
	input wire route_pkg::word_t mem_rdata,
	output route_pkg::node_id_t next_hop,
	output logic hop_valid,
	output logic finished
);
	import route_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_read_list,
		s_read_id,
		s_get_id,
		s_finish
	} policy_state_t;

	localparam logic [15:0] LFSR_SEED = 16'hACE1;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	policy_state_t state;
	logic [15:0] lfsr;
	nbr_cnt_t pick;
	logic explore;

	// low byte against epsilon decides exploration
	assign explore = (lfsr[7:0] < epsilon) && (better_count != '0);

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= s_idle;
			lfsr <= LFSR_SEED;
			next_hop <= NO_HOP;
			hop_valid <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (go) begin
						lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0);
						if (!best_valid) begin
							next_hop <= NO_HOP;
							hop_valid <= 1'b0;
							state <= s_finish;
						end else if (explore) begin
							// random slot in the better-neighbor list
							pick <= nbr_cnt_t'(lfsr[15:8] % better_count);
							state <= s_read_list;
						end else begin
							next_hop <= best_id;
							hop_valid <= 1'b1;
							state <= s_finish;
						end
					end
				end
				s_read_list: state <= s_read_id;
				s_read_id: state <= s_get_id;
				s_get_id: begin
					next_hop <= mem_rdata;
					hop_valid <= 1'b1;
					state <= s_finish;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// list entry comes back as a neighbor index
	always_comb begin
		mem_addr = BETTER_BASE + mem_addr_t'(pick);
		if (state == s_read_id) begin
			mem_addr = nbr_addr(nbr_cnt_t'(mem_rdata[$bits(nbr_idx_t)-1:0]), FLD_ID);
		end
	end

	// read-only stage
	assign mem_we = 1'b0;
	assign mem_wdata = '0;
	assign finished = (state == s_finish);

endmodule

`default_nettype wire

//--- logic/route_engine.sv
`timescale 1ns/1ps
`default_nettype none

module route_engine (
	input wire clock,
	input wire nrst,
	input wire start,
	output logic busy,
	output logic done,
	output logic learn_go,
	output logic find_go,
	output logic choose_go,
	input wire learn_fin,
	input wire find_fin,
	input wire choose_fin,
	input wire route_pkg::mem_addr_t learn_addr,
	input wire learn_we,
	input wire route_pkg::word_t learn_wdata,
	input wire route_pkg::mem_addr_t find_addr,
	input wire find_we,
	input wire route_pkg::word_t find_wdata,
	input wire route_pkg::mem_addr_t choose_addr,
	input wire choose_we,
	input wire route_pkg::word_t choose_wdata,
	input wire route_pkg::mem_addr_t apb_addr,
	input wire apb_we,
	input wire route_pkg::word_t apb_wdata,
	output route_pkg::mem_addr_t mem_addr,
	output logic mem_we,
	output route_pkg::word_t mem_wdata
);
	import ctrl_pkg::*;

	engine_state_t state;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= st_idle;
			learn_go <= 1'b0;
			find_go <= 1'b0;
			choose_go <= 1'b0;
		end else begin
			learn_go <= 1'b0;
			find_go <= 1'b0;
			choose_go <= 1'b0;
			case (state)
				st_idle, st_done: begin
					if (start) begin
						state <= st_learn;
						learn_go <= 1'b1;
					end
				end
				st_learn: begin
					if (learn_fin) begin
						state <= st_find;
						find_go <= 1'b1;
					end
				end
				st_find: begin
					if (find_fin) begin
						state <= st_choose;
						choose_go <= 1'b1;
					end
				end
				st_choose: if (choose_fin) state <= st_done;
				default: state <= st_idle;
			endcase
		end
	end

	assign busy = (state == st_learn) || (state == st_find) || (state == st_choose);
	assign done = (state == st_done);

	// port goes to the active stage, to apb otherwise
	always_comb begin
		case (state)
			st_learn: begin
				mem_addr = learn_addr;
				mem_we = learn_we;
				mem_wdata = learn_wdata;
			end
			st_find: begin
				mem_addr = find_addr;
				mem_we = find_we;
				mem_wdata = find_wdata;
			end
			st_choose: begin
				mem_addr = choose_addr;
				mem_we = choose_we;
				mem_wdata = choose_wdata;
			end
			default: begin
				mem_addr = apb_addr;
				mem_we = apb_we;
				mem_wdata = apb_wdata;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/route_top.sv
`timescale 1ns/1ps
`default_nettype none

module route_top #(
	parameter int max_neighbors = 64
) (
	input wire clock,
	input wire nrst,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [12:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic done
);
	import route_pkg::*;

	logic start;
	logic busy;
	logic hop_valid;
	logic best_valid;
	logic [7:0] epsilon;
	node_id_t next_hop;
	node_id_t best_id;
	node_id_t my_cluster;
	node_id_t pkt_src;
	node_id_t pkt_cluster;
	word_t pkt_battery;
	cost_t my_cost;
	cost_t pkt_cost;
	nbr_cnt_t better_count;

	logic learn_go;
	logic find_go;
	logic choose_go;
	logic learn_fin;
	logic find_fin;
	logic choose_fin;

	// one memory bus per requester
	mem_addr_t apb_addr;
	mem_addr_t learn_addr;
	mem_addr_t find_addr;
	mem_addr_t choose_addr;
	mem_addr_t mem_addr;
	logic apb_we;
	logic learn_we;
	logic find_we;
	logic choose_we;
	logic mem_we;
	word_t apb_wdata;
	word_t learn_wdata;
	word_t find_wdata;
	word_t choose_wdata;
	word_t mem_wdata;
	word_t mem_rdata;

	apb_regs u_apb_regs (
		.clock(clock),
		.nrst(nrst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.done(done),
		.next_hop(next_hop),
		.hop_valid(hop_valid),
		.start(start),
		// own identifier is host readback only
		.my_id(),
		.my_cluster(my_cluster),
		.my_cost(my_cost),
		.epsilon(epsilon),
		.pkt_src(pkt_src),
		.pkt_cluster(pkt_cluster),
		.pkt_battery(pkt_battery),
		.pkt_cost(pkt_cost),
		.mem_addr(apb_addr),
		.mem_we(apb_we),
		.mem_wdata(apb_wdata),
		.mem_rdata(mem_rdata)
	);

	route_engine u_engine (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.busy(busy),
		.done(done),
		.learn_go(learn_go),
		.find_go(find_go),
		.choose_go(choose_go),
		.learn_fin(learn_fin),
		.find_fin(find_fin),
		.choose_fin(choose_fin),
		.learn_addr(learn_addr),
		.learn_we(learn_we),
		.learn_wdata(learn_wdata),
		.find_addr(find_addr),
		.find_we(find_we),
		.find_wdata(find_wdata),
		.choose_addr(choose_addr),
		.choose_we(choose_we),
		.choose_wdata(choose_wdata),
		.apb_addr(apb_addr),
		.apb_we(apb_we),
		.apb_wdata(apb_wdata),
		.mem_addr(mem_addr),
		.mem_we(mem_we),
		.mem_wdata(mem_wdata)
	);

	learn_costs #(
		.max_neighbors(max_neighbors)
	) u_learn (
		.clock(clock),
		.nrst(nrst),
		.go(learn_go),
		.pkt_src(pkt_src),
		.pkt_cluster(pkt_cluster),
		.pkt_battery(pkt_battery),
		.pkt_cost(pkt_cost),
		.mem_addr(learn_addr),
		.mem_we(learn_we),
		.mem_wdata(learn_wdata),
		.mem_rdata(mem_rdata),
		.finished(learn_fin)
	);

	find_best #(
		.max_neighbors(max_neighbors)
	) u_find (
		.clock(clock),
		.nrst(nrst),
		.go(find_go),
		.my_cluster(my_cluster),
		.my_cost(my_cost),
		.mem_addr(find_addr),
		.mem_we(find_we),
		.mem_wdata(find_wdata),
		.mem_rdata(mem_rdata),
		.best_id(best_id),
		.best_valid(best_valid),
		.better_count(better_count),
		.finished(find_fin)
	);

	winner_policy u_policy (
		.clock(clock),
		.nrst(nrst),
		.go(choose_go),
		.epsilon(epsilon),
		.best_id(best_id),
		.best_valid(best_valid),
		.better_count(better_count),
		.mem_addr(choose_addr),
		.mem_we(choose_we),
		.mem_wdata(choose_wdata),
		.mem_rdata(mem_rdata),
		.next_hop(next_hop),
		.hop_valid(hop_valid),
		.finished(choose_fin)
	);

	node_memory u_mem (
		.clock(clock),
		.addr(mem_addr),
		.we(mem_we),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

`default_nettype wire

//--- sim/route_props.sv
`timescale 1ns/1ps
`default_nettype none

module route_props (
	input wire clock,
	input wire nrst,
	input wire start,
	input wire busy,
	input wire done,
	input wire pready,
	input wire pslverr
);

	// done takes over from busy in the same cycle
	a_busy_done: assert property (@(posedge clock) disable iff (!nrst)
		($rose(done) || $fell(busy)) |-> ($rose(done) && $fell(busy)))
		else $error("done and busy did not change over in the same cycle");

	a_start_busy: assert property (@(posedge clock) disable iff (!nrst)
		start && !busy |=> busy)
		else $error("start from idle did not make the engine busy");

	// error response only in the completing cycle
	a_err_ready: assert property (@(posedge clock) disable iff (!nrst) pslverr |-> pready)
		else $error("pslverr without pready");

endmodule

bind route_top route_props u_props (
	.clock(clock),
	.nrst(nrst),
	.start(start),
	.busy(busy),
	.done(done),
	.pready(pready),
	.pslverr(pslverr)
);

`default_nettype wire

//--- sim/route_tb.sv
`timescale 1ns/1ps
`default_nettype none

module route_tb;
	import route_pkg::*;
	import ctrl_pkg::*;

	localparam int MAX_NBR = 64;
	localparam int TABLE_LEN = 24;
	localparam int EXPLORE_RUNS = 8;
	localparam int NUM_RUNS = 2 + 1 + EXPLORE_RUNS + 1 + 1;
	// worst case of one run over a table one entry longer than loaded
	localparam int RUN_CYCLES = (4 * (TABLE_LEN + 1) + 6) + (4 * (TABLE_LEN + 1) + 4) + 8;
	// bus transfers of all tests at up to four cycles each
	localparam int NUM_XFERS = 4 * (4 * TABLE_LEN + 1) + 16 * NUM_RUNS + 4 * TABLE_LEN + 40;
	localparam int TIMEOUT_CYCLES = 2 * (NUM_RUNS * RUN_CYCLES + 4 * NUM_XFERS) + 2000;

	logic clock = 1'b0;
	logic nrst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [12:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic done;

	// reference neighbor table with words id, cluster, battery and q
	logic [15:0] m_tab [0:MAX_NBR-1][0:3];
	int m_count;
	int exp_better[$];
	logic exp_valid;
	logic [15:0] exp_best;

	logic [31:0] rng_state = 32'd41231;
	string cur_test;
	int test_errors;
	int total_errors = 0;
	int num_checks = 0;
	int num_tests = 0;
	int cycles = 0;

	route_top #(
		.max_neighbors(MAX_NBR)
	) u_dut (
		.clock(clock),
		.nrst(nrst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.done(done)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the engine or the bus never finished", cycles);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		num_checks++;
		if (actual !== expected) begin
			test_errors++;
			total_errors++;
			$display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors = 0;
		num_tests++;
	endtask

	task automatic end_test();
		$display("%-12s %0d errors", cur_test, test_errors);
	endtask

	// one apb transfer with setup then access until pready
	task automatic apb_xfer(input logic wr, input logic [12:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err, output int waits);
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clock);
		penable <= 1'b1;
		waits = 0;
		@(posedge clock);
		while (pready !== 1'b1) begin
			waits++;
			@(posedge clock);
		end
		rdata = prdata;
		err = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_write(input logic [12:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		int waits;
		apb_xfer(1'b1, addr, data, rd, err, waits);
		check_value("pslverr on write", 0, err);
	endtask

	task automatic apb_read(input logic [12:0] addr, output logic [31:0] data, output int waits);
		logic err;
		apb_xfer(1'b0, addr, 32'h0, data, err, waits);
		check_value("pslverr on read", 0, err);
	endtask

	task automatic mem_write(input int word_addr, input logic [15:0] data);
		apb_write(MEM_WINDOW + 13'(word_addr * 4), {16'h0, data});
	endtask

	task automatic mem_read(input int word_addr, output logic [31:0] data, output int waits);
		apb_read(MEM_WINDOW + 13'(word_addr * 4), data, waits);
	endtask

	task automatic set_config(input logic [15:0] cluster, input logic [15:0] cost,
			input logic [7:0] eps);
		apb_write(REG_MY_CLUSTER, {16'h0, cluster});
		apb_write(REG_MY_COST, {16'h0, cost});
		apb_write(REG_EPSILON, {24'h0, eps});
	endtask

	// every fifth entry sits in cluster 2 below the node's own cost
	task automatic load_table(input int n);
		logic [31:0] r;
		logic [31:0] s;
		for (int i = 0; i < n; i++) begin
			r = next_random();
			s = next_random();
			m_tab[i][0] = {8'(i), r[7:0]};
			m_tab[i][1] = (i % 5 == 0) ? 16'd2 : 16'((r[9:8] % 3) + 1);
			m_tab[i][2] = r[31:16];
			m_tab[i][3] = (i % 5 == 0) ? {1'b0, s[14:0]} : s[15:0];
			for (int f = 0; f < 4; f++) begin
				mem_write(NBR_BASE + 4 * i + f, m_tab[i][f]);
			end
		end
		m_count = n;
		mem_write(NBR_COUNT_ADDR, 16'(n));
	endtask

	task automatic model_learn(input logic [15:0] src, input logic [15:0] cl,
			input logic [15:0] bat, input logic [15:0] q);
		int hit;
		hit = -1;
		for (int i = 0; i < m_count; i++) begin
			if (hit < 0 && m_tab[i][0] == src) begin
				hit = i;
			end
		end
		// unknown source appends while there is room
		if (hit < 0 && m_count < MAX_NBR) begin
			hit = m_count;
			m_count++;
			m_tab[hit][0] = src;
		end
		if (hit >= 0) begin
			m_tab[hit][1] = cl;
			m_tab[hit][2] = bat;
			m_tab[hit][3] = q;
		end
	endtask

	task automatic model_expect(input logic [15:0] my_cluster, input logic [15:0] my_cost);
		logic [15:0] best_q;
		exp_better.delete();
		exp_valid = 1'b0;
		exp_best = NO_HOP;
		best_q = '0;
		for (int i = 0; i < m_count; i++) begin
			if (m_tab[i][1] == my_cluster) begin
				if (!exp_valid || m_tab[i][3] < best_q) begin
					exp_valid = 1'b1;
					best_q = m_tab[i][3];
					exp_best = m_tab[i][0];
				end
				if (m_tab[i][3] < my_cost) begin
					exp_better.push_back(i);
				end
			end
		end
	endtask

	task automatic send_packet(input logic [15:0] src, input logic [15:0] cl,
			input logic [15:0] bat, input logic [15:0] q);
		apb_write(REG_PKT_SRC, {16'h0, src});
		apb_write(REG_PKT_CLUSTER, {16'h0, cl});
		apb_write(REG_PKT_BATTERY, {16'h0, bat});
		apb_write(REG_PKT_COST, {16'h0, q});
		model_learn(src, cl, bat, q);
	endtask

	// refresh a known neighbor with new values
	task automatic random_packet();
		logic [31:0] r;
		logic [31:0] s;
		int idx;
		r = next_random();
		s = next_random();
		idx = int'(r[15:0]) % m_count;
		send_packet(m_tab[idx][0], 16'((r[17:16] % 3) + 1), s[31:16], s[15:0]);
	endtask

	task automatic wait_done();
		while (done === 1'b1) begin
			@(posedge clock);
		end
		while (done !== 1'b1) begin
			@(posedge clock);
		end
	endtask

	task automatic run_engine();
		apb_write(REG_CTRL, 32'h1);
		wait_done();
	endtask

	task automatic check_table();
		logic [31:0] rd;
		int waits;
		mem_read(NBR_COUNT_ADDR, rd, waits);
		check_value("neighbor count", m_count, rd);
		for (int i = 0; i < m_count; i++) begin
			for (int f = 0; f < 4; f++) begin
				mem_read(NBR_BASE + 4 * i + f, rd, waits);
				check_value($sformatf("entry %0d word %0d", i, f), {16'h0, m_tab[i][f]}, rd);
			end
		end
	endtask

	task automatic check_better_list();
		logic [31:0] rd;
		int waits;
		mem_read(BETTER_COUNT_ADDR, rd, waits);
		check_value("better count", exp_better.size(), rd);
		foreach (exp_better[k]) begin
			mem_read(BETTER_BASE + k, rd, waits);
			check_value($sformatf("better entry %0d", k), exp_better[k], rd);
		end
	endtask

	task automatic test_reset();
		logic [31:0] rd;
		int waits;
		begin_test("reset");
		apb_read(REG_STATUS, rd, waits);
		check_value("status", 0, rd);
		check_value("register wait states", 0, waits);
		apb_read(REG_NEXT_HOP, rd, waits);
		check_value("next hop", {16'h0, NO_HOP}, rd);
		// only the low half of a word is kept, epsilon holds eight bits
		apb_write(REG_MY_ID, 32'hFFFF3C5A);
		apb_read(REG_MY_ID, rd, waits);
		check_value("my id", 32'h00003C5A, rd);
		apb_write(REG_EPSILON, 32'h000001A5);
		apb_read(REG_EPSILON, rd, waits);
		check_value("epsilon", 32'h000000A5, rd);
		mem_write(11'h300, 16'hA5C3);
		mem_read(11'h300, rd, waits);
		check_value("window data", 32'h0000A5C3, rd);
		check_value("window wait states", 1, waits);
		end_test();
	endtask

	task automatic test_learn();
		begin_test("learn");
		set_config(16'd2, 16'h8000, 8'd0);
		load_table(3);
		send_packet(m_tab[1][0], 16'd3, 16'h0042, 16'h0123);
		run_engine();
		check_table();
		// source outside the table grows it by one
		send_packet(16'h7E7E, 16'd1, 16'h0099, 16'h0055);
		run_engine();
		check_table();
		end_test();
	endtask

	task automatic test_greedy();
		logic [31:0] rd;
		int waits;
		begin_test("greedy");
		load_table(TABLE_LEN);
		set_config(16'd2, 16'h8000, 8'd0);
		random_packet();
		run_engine();
		model_expect(16'd2, 16'h8000);
		apb_read(REG_NEXT_HOP, rd, waits);
		check_value("next hop", {16'h0, exp_best}, rd);
		apb_read(REG_STATUS, rd, waits);
		check_value("status", 32'({exp_valid, 2'b10}), rd);
		check_better_list();
		end_test();
	endtask

	task automatic test_explore();
		logic [31:0] rd;
		int waits;
		logic found;
		begin_test("explore");
		set_config(16'd2, 16'h8000, 8'd255);
		repeat (EXPLORE_RUNS) begin
			random_packet();
			run_engine();
			model_expect(16'd2, 16'h8000);
			apb_read(REG_STATUS, rd, waits);
			check_value("status", 32'({exp_valid, 2'b10}), rd);
			apb_read(REG_NEXT_HOP, rd, waits);
			if (exp_better.size() > 0) begin
				found = 1'b0;
				foreach (exp_better[k]) begin
					if (m_tab[exp_better[k]][0] == rd[15:0]) begin
						found = 1'b1;
					end
				end
				check_value("next hop in better set", 1, found);
			end else begin
				check_value("next hop", {16'h0, exp_best}, rd);
			end
		end
		end_test();
	endtask

	task automatic test_no_cluster();
		logic [31:0] rd;
		int waits;
		begin_test("no_cluster");
		set_config(16'h0077, 16'h8000, 8'd0);
		random_packet();
		run_engine();
		apb_read(REG_STATUS, rd, waits);
		check_value("status", 32'h2, rd);
		apb_read(REG_NEXT_HOP, rd, waits);
		check_value("next hop", {16'h0, NO_HOP}, rd);
		mem_read(BETTER_COUNT_ADDR, rd, waits);
		check_value("better count", 0, rd);
		end_test();
	endtask

	task automatic test_busy_access();
		logic [31:0] rd;
		logic err;
		int waits;
		begin_test("busy_access");
		mem_write(11'h3A0, 16'h1234);
		set_config(16'd2, 16'h8000, 8'd0);
		random_packet();
		apb_write(REG_CTRL, 32'h1);
		// the table scan keeps the engine busy across both accesses
		apb_xfer(1'b1, MEM_WINDOW + 13'(11'h3A0 * 4), 32'h0000DEAD, rd, err, waits);
		check_value("pslverr on busy write", 1, err);
		apb_xfer(1'b0, MEM_WINDOW + 13'(11'h3A0 * 4), 32'h0, rd, err, waits);
		check_value("pslverr on busy read", 1, err);
		check_value("busy read data", 0, rd);
		wait_done();
		mem_read(11'h3A0, rd, waits);
		check_value("memory after busy write", 32'h00001234, rd);
		end_test();
	endtask

	initial begin
		nrst = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (5) @(posedge clock);
		nrst <= 1'b1;
		test_reset();
		test_learn();
		test_greedy();
		test_explore();
		test_no_cluster();
		test_busy_access();
		$display("%0d tests, %0d checks, %0d errors", num_tests, num_checks, total_errors);
		if (total_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
logic/route_pkg.sv
logic/ctrl_pkg.sv
logic/node_memory.sv
logic/apb_regs.sv
logic/learn_costs.sv
logic/find_best.sv
logic/winner_policy.sv
logic/route_engine.sv
logic/route_top.sv
sim/route_props.sv
sim/route_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= route_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Test passed
VFLAGS ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
